// ==== include/ctr_macros.svh ====
// Sizing macros for the CTR increment engine
// Counter width, slice size and Wishbone widths

`ifndef CTR_MACROS_SVH
`define CTR_MACROS_SVH

// Full counter width in bits
`define CTR_WIDTH 128

// Bits added per clock cycle
`define CTR_SLICE_SIZE 16

// Wishbone data width
`define CTR_WB_DW 32

// Word address width, eight registers
`define CTR_WB_AW 3

`endif

// ==== sim/ctr_unit_tb.sv ====
`timescale 1ns/10ps
// Testbench for the CTR increment engine
// Wishbone bus tasks, reference model and compare process
// Reset, readback, increment, busy window and error scenarios, watchdog

module ctr_unit_tb;

  import ctr_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_RAND   = 40;
  localparam int NUM_CORNER = 4;
  localparam int NUM_WORDS  = $bits(ctr_t) / $bits(wb_data_t);
  // Accepted and ignored increment commands
  localparam int NUM_INCR   = NUM_RAND + NUM_CORNER + 3;
  // Roughly 30 bus cycles per increment test
  localparam int WATCHDOG_CYCLES = NUM_INCR * 40 + 200;

  logic     clk_i;
  logic     rst_ni;
  logic     wb_cyc_i;
  logic     wb_stb_i;
  logic     wb_we_i;
  wb_addr_t wb_adr_i;
  wb_data_t wb_dat_i;
  wb_data_t wb_dat_o;
  logic     wb_ack_o;
  logic     alert_o;
  integer   seed;

  // Results waiting for the compare process
  ctr_t     got_ctr_q [$];
  ctr_t     exp_ctr_q [$];
  string    ctr_tag_q [$];
  wb_data_t got_st_q  [$];
  wb_data_t exp_st_q  [$];
  string    st_tag_q  [$];
  logic     got_al_q  [$];
  logic     exp_al_q  [$];
  string    al_tag_q  [$];

  ctr_unit_top dut (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .alert_o  (alert_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////
  // Reference and checks
  ////////////////////

  // Counter wraps modulo 2^128
  function automatic ctr_t ctr_next(input ctr_t val);
    return val + ctr_t'(1);
  endfunction

  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1, "Run stopped at first failure");
  endtask

  task automatic check_ctr(input ctr_t got, input ctr_t exp, input string tag);
    if (got !== exp) begin
      $display("Fail at %0t: %s counter %h, expected %h", $time, tag, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_status(input wb_data_t got, input wb_data_t exp, input string tag);
    if (got !== exp) begin
      $display("Fail at %0t: %s word %h, expected %h", $time, tag, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_alert(input logic got, input logic exp, input string tag);
    if (got !== exp) begin
      $display("Fail at %0t: %s alert_o %b, expected %b", $time, tag, got, exp);
      stop_with_failure();
    end
  endtask

  // Compares on the falling edge, away from bus activity
  initial begin : compare_results
    forever begin
      @(negedge clk_i);
      while (got_ctr_q.size() > 0) begin
        check_ctr(got_ctr_q.pop_front(), exp_ctr_q.pop_front(), ctr_tag_q.pop_front());
      end
      while (got_st_q.size() > 0) begin
        check_status(got_st_q.pop_front(), exp_st_q.pop_front(), st_tag_q.pop_front());
      end
      while (got_al_q.size() > 0) begin
        check_alert(got_al_q.pop_front(), exp_al_q.pop_front(), al_tag_q.pop_front());
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    stop_with_failure();
  end

  ////////////////////
  // Bus tasks
  ////////////////////

  // Inputs change 2 ns after the rising edge
  task automatic wait_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
  endtask

  // One classic cycle, called 2 ns after an edge
  task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                            output wb_data_t rdat);
    int n;
    n        = 0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    do begin
      wait_cycle();
      n++;
    end while (!wb_ack_o && n < 10);
    if (!wb_ack_o) begin
      $display("No Wishbone ack within 10 cycles for address %0d", adr);
      stop_with_failure();
    end
    rdat     = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
    wb_data_t unused;
    bus_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_data_t data);
    bus_access(1'b0, adr, '0, data);
  endtask

  task automatic write_ctr(input ctr_t val);
    for (int k = 0; k < NUM_WORDS; k++) begin
      wb_write(wb_addr_t'(k), val[k*$bits(wb_data_t) +: $bits(wb_data_t)]);
    end
  endtask

  task automatic read_ctr(output ctr_t val);
    ctr_t     acc;
    wb_data_t w;
    for (int k = 0; k < NUM_WORDS; k++) begin
      wb_read(wb_addr_t'(k), w);
      acc[k*$bits(wb_data_t) +: $bits(wb_data_t)] = w;
    end
    val = acc;
  endtask

  // Status lags a command by one cycle
  task automatic poll_idle();
    wb_data_t st;
    int       n;
    n = 0;
    wait_cycle();
    do begin
      wb_read(ADDR_STATUS, st);
      n++;
    end while (!st[0] && n < 50);
    if (!st[0]) begin
      $display("The engine did not return to idle after 50 status reads");
      stop_with_failure();
    end
  endtask

  ////////////////////
  // Scenario helpers
  ////////////////////

  task automatic expect_ctr(input ctr_t exp, input string tag);
    ctr_t got;
    read_ctr(got);
    got_ctr_q.push_back(got);
    exp_ctr_q.push_back(exp);
    ctr_tag_q.push_back(tag);
  endtask

  task automatic expect_word(input wb_addr_t adr, input wb_data_t exp, input string tag);
    wb_data_t got;
    wb_read(adr, got);
    got_st_q.push_back(got);
    exp_st_q.push_back(exp);
    st_tag_q.push_back(tag);
  endtask

  task automatic expect_alert(input logic exp, input string tag);
    got_al_q.push_back(alert_o);
    exp_al_q.push_back(exp);
    al_tag_q.push_back(tag);
  endtask

  task automatic check_reset_state(input string tag);
    expect_word(ADDR_STATUS, wb_data_t'(1), tag);
    expect_alert(1'b0, tag);
    expect_ctr('0, tag);
  endtask

  task automatic incr_check(input ctr_t val, input string tag);
    write_ctr(val);
    wb_write(ADDR_CMD, CMD_INCR);
    poll_idle();
    expect_ctr(ctr_next(val), tag);
  endtask

  initial begin : main
    ctr_t val;
    ctr_t corner [NUM_CORNER];
    seed     = 71475;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    apply_reset();
    check_reset_state("after reset");

    // Word readback, unmapped addresses, zero command
    val = {$random(seed), $random(seed), $random(seed), $random(seed)};
    write_ctr(val);
    expect_ctr(val, "word readback");
    wb_write(wb_addr_t'(6), 32'hffff_ffff);
    wb_write(wb_addr_t'(7), 32'h5a5a_5a5a);
    expect_word(wb_addr_t'(6), '0, "address 6");
    expect_word(wb_addr_t'(7), '0, "address 7");
    expect_ctr(val, "after writes to 6 and 7");
    wb_write(ADDR_CMD, '0);
    expect_word(ADDR_STATUS, wb_data_t'(1), "zero command");
    expect_ctr(val, "zero command");

    for (int i = 0; i < NUM_RAND; i++) begin
      val = {$random(seed), $random(seed), $random(seed), $random(seed)};
      incr_check(val, $sformatf("random increment %0d", i));
    end

    // Long carry chains and the wrap to zero
    corner[0] = {32'h1234_5678, {96{1'b1}}};
    corner[1] = {64'h0, {64{1'b1}}};
    corner[2] = {112'h0, 16'hffff};
    corner[3] = '1;
    for (int i = 0; i < NUM_CORNER; i++) begin
      incr_check(corner[i], $sformatf("corner increment %0d", i));
    end

    // Word write and second command inside the busy window
    val = {$random(seed), $random(seed), $random(seed), $random(seed)};
    write_ctr(val);
    wb_write(ADDR_CMD, CMD_INCR);
    wait_cycle();
    wb_write(ADDR_CTR0, 32'hdead_beef);
    wb_write(ADDR_CMD, CMD_INCR);
    poll_idle();
    expect_ctr(ctr_next(val), "busy window");

    // Invalid command locks the engine until reset
    val = {$random(seed), $random(seed), $random(seed), $random(seed)};
    write_ctr(val);
    wb_write(ADDR_CMD, 32'h0000_0005);
    wait_cycle();
    expect_word(ADDR_STATUS, wb_data_t'(2), "error status");
    expect_alert(1'b1, "error state");
    wb_write(ADDR_CMD, CMD_INCR);
    wb_write(ADDR_CTR1, 32'h0bad_0bad);
    repeat (10) wait_cycle();
    expect_ctr(val, "error state");
    expect_word(ADDR_STATUS, wb_data_t'(2), "error status held");
    apply_reset();
    check_reset_state("after second reset");

    // Let the compare process drain its queues
    repeat (2) wait_cycle();
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
src/ctr_pkg.sv
src/ctr_wb_regs.sv
src/ctr_incr_fsm.sv
src/ctr_slice_store.sv
src/ctr_unit_top.sv
sim/ctr_unit_tb.sv

// ==== src/ctr_incr_fsm.sv ====
`timescale 1ns/10ps
// Control stage of the CTR increment engine
// Slice walk with carry propagation and terminal error state

`include "ctr_macros.svh"

module ctr_incr_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                incr_i,
  input  logic                incr_err_i,
  output logic                ready_o,
  output logic                alert_o,

  // Slice port of the storage stage
  output ctr_pkg::slice_idx_t slice_idx_o,
  input  ctr_pkg::ctr_slice_t slice_i,
  output ctr_pkg::ctr_slice_t slice_o,
  output logic                slice_we_o
);

  import ctr_pkg::*;

  ctr_state_e               state_d;
  ctr_state_e               state_q;
  slice_idx_t               idx_d;
  slice_idx_t               idx_q;
  logic                     carry_d;
  logic                     carry_q;
  logic [`CTR_SLICE_SIZE:0] sum;

  ////////////////////
  // Datapath
  ////////////////////

  // One slice plus carry, top bit is carry-out
  assign sum         = {1'b0, slice_i} + {{`CTR_SLICE_SIZE{1'b0}}, carry_q};
  assign slice_o     = sum[`CTR_SLICE_SIZE-1:0];
  assign slice_idx_o = idx_q;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    ready_o    = 1'b0;
    alert_o    = 1'b0;
    slice_we_o = 1'b0;
    state_d    = state_q;
    idx_d      = idx_q;
    carry_d    = carry_q;

    case (state_q)
      CTR_IDLE: begin
        ready_o = 1'b1;
        if (incr_i) begin
          // Start at slice 0 with carry set
          idx_d   = '0;
          carry_d = 1'b1;
          state_d = CTR_INCR;
        end
      end
      CTR_INCR: begin
        slice_we_o = 1'b1;
        idx_d      = idx_q + slice_idx_t'(1);
        carry_d    = sum[`CTR_SLICE_SIZE];
        // Done after the top slice
        if (idx_q == '1) begin
          state_d = CTR_IDLE;
        end
      end
      CTR_ERROR: begin
        // Terminal, only reset leaves
        alert_o = 1'b1;
      end
      default: begin
        // Illegal encoding
        alert_o = 1'b1;
        state_d = CTR_ERROR;
      end
    endcase

    // Bad command wins from any state
    if (incr_err_i) begin
      state_d = CTR_ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CTR_IDLE;
      idx_q   <= '0;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
      carry_q <= carry_d;
    end
  end

endmodule

// ==== src/ctr_pkg.sv ====
// Shared types for the CTR increment engine
// Counter, slice, index and bus typedefs, control states
// Register map and command constants

`include "ctr_macros.svh"

package ctr_pkg;

  ////////////////////
  // Data types
  ////////////////////

  typedef logic [`CTR_WIDTH-1:0]      ctr_t;
  typedef logic [`CTR_SLICE_SIZE-1:0] ctr_slice_t;

  // Slice 0 is least significant
  typedef logic [$clog2(`CTR_WIDTH/`CTR_SLICE_SIZE)-1:0] slice_idx_t;

  typedef logic [`CTR_WB_DW-1:0] wb_data_t;
  typedef logic [`CTR_WB_AW-1:0] wb_addr_t;

  // Selects one 32-bit word of the counter
  typedef logic [$clog2(`CTR_WIDTH/`CTR_WB_DW)-1:0] ctr_word_idx_t;

  // Control states, pairwise Hamming distance of two
  typedef enum logic [2:0] {
    CTR_IDLE  = 3'b011,
    CTR_INCR  = 3'b101,
    CTR_ERROR = 3'b110
  } ctr_state_e;

  ////////////////////
  // Register map
  ////////////////////

  // Counter words, least significant first
  localparam wb_addr_t ADDR_CTR0   = wb_addr_t'(0);
  localparam wb_addr_t ADDR_CTR1   = wb_addr_t'(1);
  localparam wb_addr_t ADDR_CTR2   = wb_addr_t'(2);
  localparam wb_addr_t ADDR_CTR3   = wb_addr_t'(3);
  localparam wb_addr_t ADDR_CMD    = wb_addr_t'(4);
  localparam wb_addr_t ADDR_STATUS = wb_addr_t'(5);

  // Only valid nonzero command word
  localparam wb_data_t CMD_INCR = wb_data_t'(32'h0000_000A);

endpackage

// ==== src/ctr_slice_store.sv ====
`timescale 1ns/10ps
// Storage stage of the CTR increment engine
// Eight slice registers, slice read/write port, bus word write port

`include "ctr_macros.svh"

module ctr_slice_store (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Slice port from the control stage
  input  ctr_pkg::slice_idx_t    slice_idx_i,
  output ctr_pkg::ctr_slice_t    slice_o,
  input  ctr_pkg::ctr_slice_t    slice_i,
  input  logic                   slice_we_i,

  // Word port from the bus stage
  input  logic                   word_we_i,
  input  ctr_pkg::ctr_word_idx_t word_idx_i,
  input  ctr_pkg::wb_data_t      word_data_i,

  output ctr_pkg::ctr_t          ctr_o
);

  import ctr_pkg::*;

  localparam int unsigned NUM_SLICES      = `CTR_WIDTH / `CTR_SLICE_SIZE;
  localparam int unsigned SLICES_PER_WORD = `CTR_WB_DW / `CTR_SLICE_SIZE;

  ctr_slice_t slice_q [NUM_SLICES];

  // Indexed read for the control stage
  assign slice_o = slice_q[slice_idx_i];

  ////////////////////
  // Slice registers
  ////////////////////

  for (genvar s = 0; s < NUM_SLICES; s++) begin : g_slice
    // Word writes only arrive while the control stage is idle
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        slice_q[s] <= '0;
      end else if (slice_we_i && (slice_idx_i == slice_idx_t'(s))) begin
        slice_q[s] <= slice_i;
      end else if (word_we_i && (word_idx_i == ctr_word_idx_t'(s / SLICES_PER_WORD))) begin
        slice_q[s] <= word_data_i[(s % SLICES_PER_WORD)*`CTR_SLICE_SIZE +: `CTR_SLICE_SIZE];
      end
    end

    // Flat view for bus reads
    assign ctr_o[s*`CTR_SLICE_SIZE +: `CTR_SLICE_SIZE] = slice_q[s];
  end

endmodule

// ==== src/ctr_unit_top.sv ====
`timescale 1ns/10ps
// Top level of the CTR increment engine
// Bus stage, control stage and storage stage

module ctr_unit_top (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Wishbone classic slave
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  ctr_pkg::wb_addr_t wb_adr_i,
  input  ctr_pkg::wb_data_t wb_dat_i,
  output ctr_pkg::wb_data_t wb_dat_o,
  output logic              wb_ack_o,

  output logic              alert_o
);

  import ctr_pkg::*;

  // Bus to control
  logic          incr;
  logic          incr_err;
  logic          ready;

  // Control to storage
  slice_idx_t    slice_idx;
  ctr_slice_t    slice_rd;
  ctr_slice_t    slice_wd;
  logic          slice_we;

  // Bus to storage
  logic          word_we;
  ctr_word_idx_t word_idx;
  wb_data_t      word_data;
  ctr_t          ctr_q;

  ctr_wb_regs u_wb_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .ready_i     (ready),
    .alert_i     (alert_o),
    .incr_o      (incr),
    .incr_err_o  (incr_err),
    .ctr_i       (ctr_q),
    .word_we_o   (word_we),
    .word_idx_o  (word_idx),
    .word_data_o (word_data)
  );

  ctr_incr_fsm u_incr_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .incr_i      (incr),
    .incr_err_i  (incr_err),
    .ready_o     (ready),
    .alert_o     (alert_o),
    .slice_idx_o (slice_idx),
    .slice_i     (slice_rd),
    .slice_o     (slice_wd),
    .slice_we_o  (slice_we)
  );

  ctr_slice_store u_slice_store (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .slice_idx_i (slice_idx),
    .slice_o     (slice_rd),
    .slice_i     (slice_wd),
    .slice_we_i  (slice_we),
    .word_we_i   (word_we),
    .word_idx_i  (word_idx),
    .word_data_i (word_data),
    .ctr_o       (ctr_q)
  );

endmodule

// ==== src/ctr_wb_regs.sv ====
`timescale 1ns/10ps
// Wishbone classic slave for the CTR increment engine
// Address decode, counter word writes and command check
// Registered ack and read data

`include "ctr_macros.svh"

module ctr_wb_regs (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Wishbone classic slave
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  ctr_pkg::wb_addr_t      wb_adr_i,
  input  ctr_pkg::wb_data_t      wb_dat_i,
  output ctr_pkg::wb_data_t      wb_dat_o,
  output logic                   wb_ack_o,

  // Control stage
  input  logic                   ready_i,
  input  logic                   alert_i,
  output logic                   incr_o,
  output logic                   incr_err_o,

  // Storage stage
  input  ctr_pkg::ctr_t          ctr_i,
  output logic                   word_we_o,
  output ctr_pkg::ctr_word_idx_t word_idx_o,
  output ctr_pkg::wb_data_t      word_data_o
);

  import ctr_pkg::*;

  logic          ack_q;
  logic          req;
  logic          wr_req;
  logic          is_ctr_addr;
  logic          cmd_write;
  logic          cmd_valid;
  logic          cmd_zero;
  ctr_word_idx_t word_sel;
  wb_data_t      status;
  wb_data_t      rdata;
  wb_data_t      rdata_q;
  logic          incr_q;
  logic          incr_err_q;
  logic          word_we_q;
  ctr_word_idx_t word_idx_q;
  wb_data_t      word_data_q;

  ////////////////////
  // Decode
  ////////////////////

  // New access only while ack is low
  assign req    = wb_cyc_i & wb_stb_i & ~ack_q;
  assign wr_req = req & wb_we_i;

  // Addresses 0 to 3 hold the counter words
  assign is_ctr_addr = (wb_adr_i <= ADDR_CTR3);
  assign word_sel    = ctr_word_idx_t'(wb_adr_i);

  // Command word check
  assign cmd_write = wr_req & (wb_adr_i == ADDR_CMD);
  assign cmd_valid = (wb_dat_i == CMD_INCR);
  assign cmd_zero  = (wb_dat_i == '0);

  // Status: bit 0 ready, bit 1 alert
  assign status = wb_data_t'({alert_i, ready_i});

  // Read mux, unmapped and write-only addresses give zero
  always_comb begin
    rdata = '0;
    case (wb_adr_i)
      ADDR_CTR0, ADDR_CTR1, ADDR_CTR2, ADDR_CTR3: begin
        rdata = ctr_i[word_sel*`CTR_WB_DW +: `CTR_WB_DW];
      end
      ADDR_STATUS: begin
        rdata = status;
      end
      default: begin
        rdata = '0;
      end
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  // Control strobes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q      <= 1'b0;
      incr_q     <= 1'b0;
      incr_err_q <= 1'b0;
      word_we_q  <= 1'b0;
    end else begin
      ack_q      <= req;
      // Increment and word writes dropped while busy
      incr_q     <= cmd_write & cmd_valid & ready_i;
      incr_err_q <= cmd_write & ~cmd_valid & ~cmd_zero;
      word_we_q  <= wr_req & is_ctr_addr & ready_i;
    end
  end

  // Read data and write payload
  always_ff @(posedge clk_i) begin
    if (req) begin
      rdata_q <= rdata;
    end
    if (wr_req) begin
      word_idx_q  <= word_sel;
      word_data_q <= wb_dat_i;
    end
  end

  assign wb_ack_o    = ack_q;
  assign wb_dat_o    = rdata_q;
  assign incr_o      = incr_q;
  assign incr_err_o  = incr_err_q;
  assign word_we_o   = word_we_q;
  assign word_idx_o  = word_idx_q;
  assign word_data_o = word_data_q;

endmodule
